/* Bender.yml */
package:
  name: serial_bridge

sources:
  - files:
      - rtl/board_pkg.sv
      - rtl/ft_pkg.sv
      - rtl/fifo_byte_if.sv
      - rtl/reg_bus_if.sv
      - rtl/ft_fifo_port.sv
      - rtl/cmd_parser.sv
      - rtl/ctrl_regs.sv
      - rtl/status_sampler.sv
      - rtl/reply_serializer.sv
      - rtl/serial_bridge_top.sv
  - target: simulation
    files:
      - sim/tb_serial_bridge.sv

/* all.f */
rtl/board_pkg.sv
rtl/ft_pkg.sv
rtl/fifo_byte_if.sv
rtl/reg_bus_if.sv
rtl/ft_fifo_port.sv
rtl/cmd_parser.sv
rtl/ctrl_regs.sv
rtl/status_sampler.sv
rtl/reply_serializer.sv
rtl/serial_bridge_top.sv
sim/tb_serial_bridge.sv

/* rtl/board_pkg.sv */
package board_pkg;

    // ----------------------------------------
    // register words and map
    // ----------------------------------------
    typedef logic [31:0] reg_word_t;
    typedef logic [3:0]  reg_addr_t;

    // addresses sit in the high nibble of a header
    localparam reg_addr_t ADR_COMP_CONFIG = 4'h1;
    localparam reg_addr_t ADR_PULSE_CTRL  = 4'h2;
    localparam reg_addr_t ADR_MUX         = 4'h4;
    localparam reg_addr_t ADR_HALFSTRIPS  = 4'h5;
    localparam reg_addr_t ADR_HS_EXPECT   = 4'h6;
    localparam reg_addr_t ADR_HS_ERRCNT   = 4'h7;

    // fields as they leave the board
    typedef logic [2:0]  pktime_t;
    typedef logic [1:0]  pkmode_t;
    typedef logic [3:0]  pulse_width_t;
    typedef logic [2:0]  bx_delay_t;
    typedef logic [15:0] mux_lines_t;

    // pulse dac enable is active low, bit 5 rests high
    localparam reg_word_t PULSE_CTRL_RESET = 32'h0000_0020;

    // writable registers, as held by ctrl_regs
    typedef struct packed {
        reg_word_t comp_config;
        reg_word_t pulse_ctrl;
        reg_word_t mux;
        reg_word_t hs_expect;
    } ctrl_words_t;

    // board status after synchronization
    typedef struct packed {
        reg_word_t halfstrips;
        reg_word_t hs_errcnt;
        logic      pulser_ready;
    } status_words_t;

endpackage

/* rtl/cmd_parser.sv */
`timescale 1ns/1ps

module cmd_parser
    import ft_pkg::*;
    import board_pkg::*;
#(
    parameter bit NIBBLE_LSB = 1'b1
)
(
    input  logic        ft_clk,
    input  logic        _ft_reset,
    fifo_byte_if.parser bytes,
    reg_bus_if.master   bus
);

    parser_state_t state;
    logic [1:0]    byte_cnt;
    ft_cmd_t       hdr_cmd;
    reg_addr_t     hdr_addr;

    // header split, nibble order fixed by the host
    assign hdr_cmd  = NIBBLE_LSB ? bytes.rx_byte[3:0] : bytes.rx_byte[7:4];
    assign hdr_addr = NIBBLE_LSB ? bytes.rx_byte[7:4] : bytes.rx_byte[3:0];

    always_ff @(posedge ft_clk)
    begin
        if (_ft_reset)
        begin
            state      <= ps_idle;
            byte_cnt   <= '0;
            bus.rd_stb <= 1'b0;
        end
        else
        begin
            bus.rd_stb <= 1'b0;
            case (state)
                // four data bytes, lsb first
                ps_data:
                begin
                    if (bytes.rx_valid)
                    begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3)
                            state <= ps_commit;
                    end
                end
                // idle and commit both take a new header
                default:
                begin
                    state <= ps_idle;
                    if (bytes.rx_valid && hdr_cmd == CMD_READ)
                        bus.rd_stb <= 1'b1;
                    else if (bytes.rx_valid && hdr_cmd == CMD_WRITE)
                    begin
                        byte_cnt <= '0;
                        state    <= ps_data;
                    end
                    // anything else is dropped here
                end
            endcase
        end
    end

    // address and write word
    always_ff @(posedge ft_clk)
    begin
        if (bytes.rx_valid && state != ps_data)
            bus.addr <= hdr_addr;
        if (bytes.rx_valid && state == ps_data)
            bus.wdata <= {bytes.rx_byte, bus.wdata[31:8]};
    end

    // one cycle after the last data byte
    assign bus.wr_stb = (state == ps_commit);

endmodule

/* rtl/ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs
    import board_pkg::*;
(
    input  logic         ft_clk,
    input  logic         _ft_reset,
    reg_bus_if.regs      bus,
    output ctrl_words_t  words,
    // comparator config
    output pktime_t      pktime,
    output pkmode_t      pkmode,
    output logic         lctrst,
    output logic         _cdac_en,
    output logic         cdac_din,
    output logic         cdac_sclk,
    // pulse control
    output logic         fire_pulse,
    output pulse_width_t pulse_width,
    output logic         _pdac_en,
    output logic         pdac_din,
    output logic         pdac_sclk,
    output logic         halfstrips_errcnt_rst,
    output logic         compout_errcnt_rst,
    output logic         compin_inject,
    output bx_delay_t    bx_delay,
    // mux and halfstrips
    output mux_lines_t   mux_a0,
    output mux_lines_t   mux_a1,
    output reg_word_t    halfstrips_expect
);

    reg_word_t comp_config;
    reg_word_t pulse_ctrl;
    reg_word_t mux;
    reg_word_t hs_expect;

    always_ff @(posedge ft_clk)
    begin
        if (_ft_reset)
        begin
            comp_config <= '0;
            pulse_ctrl  <= PULSE_CTRL_RESET;
            mux         <= '0;
            hs_expect   <= '0;
        end
        else if (bus.wr_stb)
        begin
            // status addresses are read only, writes there vanish
            case (bus.addr)
                ADR_COMP_CONFIG: comp_config <= bus.wdata;
                ADR_PULSE_CTRL:  pulse_ctrl  <= bus.wdata;
                ADR_MUX:         mux         <= bus.wdata;
                ADR_HS_EXPECT:   hs_expect   <= bus.wdata;
                default:         ;
            endcase
        end
    end

    // ----------------------------------------
    // field map onto pins
    // ----------------------------------------
    assign pktime    = comp_config[2:0];
    assign pkmode    = comp_config[4:3];
    assign lctrst    = comp_config[5];
    // comparator dac bit-bang lines
    assign _cdac_en  = comp_config[6];
    assign cdac_din  = comp_config[7];
    assign cdac_sclk = comp_config[8];

    assign fire_pulse            = pulse_ctrl[0];
    assign pulse_width           = pulse_ctrl[4:1];
    // pulse dac bit-bang lines
    assign _pdac_en              = pulse_ctrl[5];
    assign pdac_din              = pulse_ctrl[6];
    assign pdac_sclk             = pulse_ctrl[7];
    assign halfstrips_errcnt_rst = pulse_ctrl[8];
    assign compout_errcnt_rst    = pulse_ctrl[9];
    assign compin_inject         = pulse_ctrl[10];
    assign bx_delay              = pulse_ctrl[13:11];

    // mux i takes bits 2i and 2i+1
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            mux_a0[i] = mux[2*i];
            mux_a1[i] = mux[2*i+1];
        end
    end

    assign halfstrips_expect = hs_expect;

    // raw words for readback
    assign words.comp_config = comp_config;
    assign words.pulse_ctrl  = pulse_ctrl;
    assign words.mux         = mux;
    assign words.hs_expect   = hs_expect;

endmodule

/* rtl/fifo_byte_if.sv */
`timescale 1ns/1ps

interface fifo_byte_if
    import ft_pkg::*;
();

    // receive side, one pulse per byte
    ft_byte_t rx_byte;
    logic     rx_valid;

    // send side, byte moves when valid and ready meet
    ft_byte_t tx_byte;
    logic     tx_valid;
    logic     tx_ready;

    // high while a read reply is still going out
    logic     reply_busy;

    modport port (
        output rx_byte, rx_valid, tx_ready,
        input  tx_byte, tx_valid, reply_busy
    );

    modport parser (
        input  rx_byte, rx_valid
    );

    modport reply (
        output tx_byte, tx_valid, reply_busy,
        input  tx_ready
    );

endinterface

/* rtl/ft_fifo_port.sv */
`timescale 1ns/1ps

module ft_fifo_port
    import ft_pkg::*;
(
    input  logic          ft_clk,
    input  logic          _ft_reset,
    input  logic          _ft_rxf,
    input  logic          _ft_txe,
    output logic          _ft_oe,
    output logic          _ft_rd,
    output logic          _ft_wr,
    inout  wire ft_byte_t ft_data,
    fifo_byte_if.port     bytes
);

    // bus phases, oe falls one cycle ahead of rd
    typedef enum logic [1:0] {
        port_idle,
        port_oe,
        port_rd,
        port_wr
    } port_state_t;

    port_state_t state;
    port_state_t state_nxt;
    ft_byte_t    tx_hold;
    logic        tx_full;
    logic        rx_open;

    // reading only with nothing to send and no reply in flight
    assign rx_open = !_ft_rxf && !tx_full && !bytes.reply_busy;

    // ----------------------------------------
    // bus scheduling
    // ----------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            // idle after a read is also the bus turnaround cycle
            port_idle:
            begin
                if (tx_full)
                    state_nxt = port_wr;
                else if (rx_open)
                    state_nxt = port_oe;
            end
            port_oe:
                state_nxt = rx_open ? port_rd : port_idle;
            // burst goes on while the chip has bytes
            port_rd:
            begin
                if (!rx_open)
                    state_nxt = port_idle;
            end
            // hold the byte until txe lets it through
            port_wr:
            begin
                if (!_ft_txe)
                    state_nxt = port_idle;
            end
            default:
                state_nxt = port_idle;
        endcase
    end

    always_ff @(posedge ft_clk)
    begin
        if (_ft_reset)
        begin
            state          <= port_idle;
            tx_full        <= 1'b0;
            bytes.rx_valid <= 1'b0;
        end
        else
        begin
            state          <= state_nxt;
            // byte taken at this edge, pulse next cycle
            bytes.rx_valid <= !_ft_rd && !_ft_rxf;
            if (state == port_wr && !_ft_txe)
                tx_full <= 1'b0;
            else if (bytes.tx_valid && !tx_full)
                tx_full <= 1'b1;
        end
    end

    // ----------------------------------------
    // byte capture and holding register
    // ----------------------------------------
    always_ff @(posedge ft_clk)
    begin
        if (!_ft_rd && !_ft_rxf)
            bytes.rx_byte <= ft_data;
        if (bytes.tx_valid && !tx_full)
            tx_hold <= bytes.tx_byte;
    end

    assign bytes.tx_ready = !tx_full;

    // strobes straight from the state flops
    assign _ft_oe  = !(state == port_oe || state == port_rd);
    assign _ft_rd  = (state != port_rd);
    assign _ft_wr  = (state != port_wr);

    // drive only in the write phase, released otherwise
    assign ft_data = (state == port_wr) ? tx_hold : 'z;

endmodule

/* rtl/ft_pkg.sv */
package ft_pkg;

    // one byte on the ft245 data bus
    typedef logic [7:0] ft_byte_t;

    // command nibble of a header byte
    typedef logic [3:0] ft_cmd_t;

    localparam ft_cmd_t CMD_READ  = 4'hA;
    localparam ft_cmd_t CMD_WRITE = 4'h5;

    // header decode, write data collection, write strobe
    typedef enum logic [1:0] {
        ps_idle,
        ps_data,
        ps_commit
    } parser_state_t;

endpackage

/* rtl/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if
    import board_pkg::*;
();

    // single cycle strobes from the parser
    logic      wr_stb;
    logic      rd_stb;
    reg_addr_t addr;
    reg_word_t wdata;

    modport master (output wr_stb, rd_stb, addr, wdata);

    // register file only cares about writes
    modport regs   (input wr_stb, addr, wdata);

    // reply side only cares about reads
    modport reply  (input rd_stb, addr);

endinterface

/* rtl/reply_serializer.sv */
`timescale 1ns/1ps

module reply_serializer
    import board_pkg::*;
(
    input  logic          ft_clk,
    input  logic          _ft_reset,
    reg_bus_if.reply      bus,
    fifo_byte_if.reply    bytes,
    input  ctrl_words_t   ctrl,
    input  status_words_t status
);

    reg_word_t  rd_word;
    reg_word_t  shift_q;
    logic [1:0] byte_cnt;
    logic       busy;

    // ----------------------------------------
    // readback select
    // ----------------------------------------
    always_comb
    begin
        case (bus.addr)
            ADR_COMP_CONFIG: rd_word = ctrl.comp_config;
            // bit 14 reads the pulser, not the register
            ADR_PULSE_CTRL:
                rd_word = {ctrl.pulse_ctrl[31:15], status.pulser_ready,
                           ctrl.pulse_ctrl[13:0]};
            ADR_MUX:         rd_word = ctrl.mux;
            ADR_HALFSTRIPS:  rd_word = status.halfstrips;
            ADR_HS_EXPECT:   rd_word = ctrl.hs_expect;
            ADR_HS_ERRCNT:   rd_word = status.hs_errcnt;
            // unmapped
            default:         rd_word = '0;
        endcase
    end

    // four bytes, one per accepted handshake
    always_ff @(posedge ft_clk)
    begin
        if (_ft_reset)
        begin
            busy     <= 1'b0;
            byte_cnt <= '0;
        end
        else if (bus.rd_stb)
        begin
            busy     <= 1'b1;
            byte_cnt <= '0;
        end
        else if (busy && bytes.tx_ready)
        begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3)
                busy <= 1'b0;
        end
    end

    // word shifts down, lsb byte always on top
    always_ff @(posedge ft_clk)
    begin
        if (bus.rd_stb)
            shift_q <= rd_word;
        else if (busy && bytes.tx_ready)
            shift_q <= {8'h00, shift_q[31:8]};
    end

    assign bytes.tx_valid   = busy;
    assign bytes.tx_byte    = shift_q[7:0];
    assign bytes.reply_busy = busy;

endmodule

/* rtl/serial_bridge_top.sv */
`timescale 1ns/1ps

module serial_bridge_top
    import board_pkg::*;
    import ft_pkg::*;
#(
    parameter bit NIBBLE_LSB  = 1'b1,
    parameter int SYNC_STAGES = 2
)
(
    // ft245 fifo
    input  logic          ft_clk,
    input  logic          _ft_reset,
    input  logic          _ft_rxf,
    input  logic          _ft_txe,
    output logic          _ft_oe,
    output logic          _ft_rd,
    output logic          _ft_wr,
    output logic          _ft_siwu,
    inout  wire ft_byte_t ft_data,
    // comparator
    output pktime_t       pktime,
    output pkmode_t       pkmode,
    output logic          lctrst,
    output logic          _cdac_en,
    output logic          cdac_din,
    output logic          cdac_sclk,
    // pulser
    output logic          fire_pulse,
    output pulse_width_t  pulse_width,
    output logic          _pdac_en,
    output logic          pdac_din,
    output logic          pdac_sclk,
    output logic          halfstrips_errcnt_rst,
    output logic          compout_errcnt_rst,
    output logic          compin_inject,
    output bx_delay_t     bx_delay,
    input  logic          pulser_ready,
    // mux and halfstrips
    output mux_lines_t    mux_a0,
    output mux_lines_t    mux_a1,
    output reg_word_t     halfstrips_expect,
    input  reg_word_t     halfstrips,
    input  reg_word_t     halfstrips_errcnt
);

    ctrl_words_t   ctrl_words;
    status_words_t status_words;

    fifo_byte_if bytes_if ();
    reg_bus_if   reg_bus ();

    // send immediate unused, keep it parked
    assign _ft_siwu = 1'b1;

    ft_fifo_port i_ft_fifo_port (
        .ft_clk, ._ft_reset, ._ft_rxf, ._ft_txe,
        ._ft_oe, ._ft_rd, ._ft_wr, .ft_data,
        .bytes (bytes_if.port)
    );

    cmd_parser #(.NIBBLE_LSB(NIBBLE_LSB)) i_cmd_parser (
        .ft_clk, ._ft_reset,
        .bytes (bytes_if.parser),
        .bus   (reg_bus.master)
    );

    // write path and status path run side by side
    ctrl_regs i_ctrl_regs (
        .ft_clk, ._ft_reset,
        .bus   (reg_bus.regs),
        .words (ctrl_words),
        .pktime, .pkmode, .lctrst, ._cdac_en, .cdac_din, .cdac_sclk,
        .fire_pulse, .pulse_width, ._pdac_en, .pdac_din, .pdac_sclk,
        .halfstrips_errcnt_rst, .compout_errcnt_rst, .compin_inject, .bx_delay,
        .mux_a0, .mux_a1, .halfstrips_expect
    );

    status_sampler #(.SYNC_STAGES(SYNC_STAGES)) i_status_sampler (
        .ft_clk, ._ft_reset,
        .halfstrips, .halfstrips_errcnt, .pulser_ready,
        .status (status_words)
    );

    // both word sources meet here
    reply_serializer i_reply_serializer (
        .ft_clk, ._ft_reset,
        .bus    (reg_bus.reply),
        .bytes  (bytes_if.reply),
        .ctrl   (ctrl_words),
        .status (status_words)
    );

endmodule

/* rtl/status_sampler.sv */
`timescale 1ns/1ps

module status_sampler
    import board_pkg::*;
#(
    parameter int SYNC_STAGES = 2
)
(
    input  logic          ft_clk,
    input  logic          _ft_reset,
    input  reg_word_t     halfstrips,
    input  reg_word_t     halfstrips_errcnt,
    input  logic          pulser_ready,
    output status_words_t status
);

    status_words_t sync_q [SYNC_STAGES];
    status_words_t sync_last;
    status_words_t sync_prev;

    // ----------------------------------------
    // synchronizer chain, all inputs together
    // ----------------------------------------
    always_ff @(posedge ft_clk)
    begin
        sync_q[0].halfstrips   <= halfstrips;
        sync_q[0].hs_errcnt    <= halfstrips_errcnt;
        sync_q[0].pulser_ready <= pulser_ready;
        for (int i = 1; i < SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];
    end

    // last stage and the sample taken one edge later
    assign sync_last = sync_q[SYNC_STAGES-1];
    assign sync_prev = sync_q[SYNC_STAGES-2];

    // commit a word only when two samples in a row agree
    // a counter caught mid-carry never gets through
    always_ff @(posedge ft_clk)
    begin
        if (_ft_reset)
            status <= '0;
        else
        begin
            if (sync_last.halfstrips == sync_prev.halfstrips)
                status.halfstrips <= sync_last.halfstrips;
            if (sync_last.hs_errcnt == sync_prev.hs_errcnt)
                status.hs_errcnt <= sync_last.hs_errcnt;
            if (sync_last.pulser_ready == sync_prev.pulser_ready)
                status.pulser_ready <= sync_last.pulser_ready;
        end
    end

endmodule

/* sim/tb_serial_bridge.sv */
`timescale 1ns/1ps

module tb_serial_bridge
    import board_pkg::*;
    import ft_pkg::*;
();

    // watchdog budget
    localparam int N_TRANS          = 16;
    localparam int CYCLES_PER_TRANS = 300;

    logic         ft_clk = 1'b0;
    logic         _ft_reset;
    logic         _ft_rxf = 1'b1;
    logic         _ft_txe = 1'b1;
    logic         _ft_oe;
    logic         _ft_rd;
    logic         _ft_wr;
    logic         _ft_siwu;
    wire ft_byte_t ft_data;
    pktime_t      pktime;
    pkmode_t      pkmode;
    logic         lctrst;
    logic         _cdac_en;
    logic         cdac_din;
    logic         cdac_sclk;
    logic         fire_pulse;
    pulse_width_t pulse_width;
    logic         _pdac_en;
    logic         pdac_din;
    logic         pdac_sclk;
    logic         halfstrips_errcnt_rst;
    logic         compout_errcnt_rst;
    logic         compin_inject;
    bx_delay_t    bx_delay;
    logic         pulser_ready;
    mux_lines_t   mux_a0;
    mux_lines_t   mux_a1;
    reg_word_t    halfstrips_expect;
    reg_word_t    halfstrips;
    reg_word_t    halfstrips_errcnt;

    // host side of the fifo chip
    ft_byte_t host_q[$];
    ft_byte_t reply_q[$];
    ft_byte_t host_data   = 8'h00;
    logic     pop_pending = 1'b0;
    int       stall_pct   = 30;
    string    test_name   = "reset";

    always #5 ft_clk = ~ft_clk;

    serial_bridge_top i_serial_bridge_top (.*);

    // ----------------------------------------
    // ft245 chip model
    // ----------------------------------------
    // chip owns the bus while oe is low
    assign ft_data = !_ft_oe ? host_data : 'z;

    // strobes only move at posedge so the
    // values seen here hold through the next edge
    always @(negedge ft_clk)
    begin
        // byte taken at the edge just gone
        if (pop_pending)
            void'(host_q.pop_front());
        _ft_rxf     = (host_q.size() == 0);
        host_data   = (host_q.size() != 0) ? host_q[0] : 8'h00;
        pop_pending = !_ft_rd && !_ft_rxf;
        // random back-pressure on the send side
        _ft_txe = (($urandom % 100) < stall_pct);
        if (!_ft_wr && !_ft_txe)
            reply_q.push_back(ft_data);
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("error %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic push_byte(input ft_byte_t b);
        host_q.push_back(b);
    endtask

    task automatic wait_drained();
        while (host_q.size() != 0 || pop_pending)
            @(negedge ft_clk);
    endtask

    // header then four bytes with the lsb first
    task automatic write_reg(input reg_addr_t addr, input reg_word_t word);
        push_byte({addr, CMD_WRITE});
        for (int i = 0; i < 4; i++)
            push_byte(word[8*i +: 8]);
        wait_drained();
        // rx pulse then wr_stb then pins
        repeat (4) @(negedge ft_clk);
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_word_t word);
        push_byte({addr, CMD_READ});
        while (reply_q.size() < 4)
            @(negedge ft_clk);
        word = {reply_q[3], reply_q[2], reply_q[1], reply_q[0]};
        for (int i = 0; i < 4; i++)
            void'(reply_q.pop_front());
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial
    begin
        repeat (CYCLES_PER_TRANS * N_TRANS) @(posedge ft_clk);
        $display("timeout in %s, run did not finish in time", test_name);
        $display("Test failed");
        $fatal(1);
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial
    begin
        reg_word_t   word;
        reg_word_t   comp_word;
        reg_word_t   rd;
        reg_word_t   exp_word;
        logic [31:0] seed_val;
        seed_val          = $urandom(32'h4bafc187);
        _ft_reset         = 1'b1;
        pulser_ready      = 1'b0;
        halfstrips        = '0;
        halfstrips_errcnt = '0;
        repeat (2) @(posedge ft_clk);
        @(negedge ft_clk);
        _ft_reset = 1'b0;

        // idle strobes and safe pulser pins
        check_value("_ft_oe", 1'b1, _ft_oe);
        check_value("_ft_rd", 1'b1, _ft_rd);
        check_value("_ft_wr", 1'b1, _ft_wr);
        check_value("_ft_siwu", 1'b1, _ft_siwu);
        check_value("_pdac_en", 1'b1, _pdac_en);
        check_value("fire_pulse", 1'b0, fire_pulse);
        check_value("halfstrips_errcnt_rst", 1'b0, halfstrips_errcnt_rst);
        check_value("compout_errcnt_rst", 1'b0, compout_errcnt_rst);
        check_value("compin_inject", 1'b0, compin_inject);
        check_value("pktime", 3'd0, pktime);

        test_name = "comp_config";
        comp_word = $urandom;
        write_reg(ADR_COMP_CONFIG, comp_word);
        check_value("pktime", comp_word[2:0], pktime);
        check_value("pkmode", comp_word[4:3], pkmode);
        check_value("lctrst", comp_word[5], lctrst);
        check_value("_cdac_en", comp_word[6], _cdac_en);
        check_value("cdac_din", comp_word[7], cdac_din);
        check_value("cdac_sclk", comp_word[8], cdac_sclk);
        read_reg(ADR_COMP_CONFIG, rd);
        check_value("readback", comp_word, rd);

        test_name = "pulse_ctrl";
        word      = $urandom;
        write_reg(ADR_PULSE_CTRL, word);
        check_value("fire_pulse", word[0], fire_pulse);
        check_value("pulse_width", word[4:1], pulse_width);
        check_value("_pdac_en", word[5], _pdac_en);
        check_value("pdac_din", word[6], pdac_din);
        check_value("pdac_sclk", word[7], pdac_sclk);
        check_value("halfstrips_errcnt_rst", word[8], halfstrips_errcnt_rst);
        check_value("compout_errcnt_rst", word[9], compout_errcnt_rst);
        check_value("compin_inject", word[10], compin_inject);
        check_value("bx_delay", word[13:11], bx_delay);
        // bit 14 reads back the pulser at both levels
        for (int lvl = 0; lvl < 2; lvl++)
        begin
            pulser_ready = lvl[0];
            repeat (10) @(negedge ft_clk);
            exp_word     = word;
            exp_word[14] = lvl[0];
            read_reg(ADR_PULSE_CTRL, rd);
            check_value("readback", exp_word, rd);
        end

        test_name = "mux";
        word      = $urandom;
        write_reg(ADR_MUX, word);
        for (int i = 0; i < 16; i++)
        begin
            check_value($sformatf("mux_a0[%0d]", i), word[2*i], mux_a0[i]);
            check_value($sformatf("mux_a1[%0d]", i), word[2*i+1], mux_a1[i]);
        end
        read_reg(ADR_MUX, rd);
        check_value("readback", word, rd);

        test_name = "halfstrips";
        for (int n = 0; n < 2; n++)
        begin
            halfstrips        = $urandom;
            halfstrips_errcnt = $urandom;
            repeat (20) @(negedge ft_clk);
            read_reg(ADR_HALFSTRIPS, rd);
            check_value("halfstrips readback", halfstrips, rd);
            read_reg(ADR_HS_ERRCNT, rd);
            check_value("errcnt readback", halfstrips_errcnt, rd);
        end
        word = $urandom;
        write_reg(ADR_HS_EXPECT, word);
        check_value("halfstrips_expect", word, halfstrips_expect);
        read_reg(ADR_HS_EXPECT, rd);
        check_value("expect readback", word, rd);

        // dropped header ahead of a read under heavy stalls
        test_name = "unknown_cmd";
        stall_pct = 70;
        push_byte({ADR_COMP_CONFIG, 4'h3});
        read_reg(ADR_COMP_CONFIG, rd);
        check_value("readback", comp_word, rd);
        repeat (30) @(negedge ft_clk);
        check_value("extra reply bytes", 32'd0, reply_q.size());

        $display("Test completed successfully");
        $finish;
    end

endmodule
